// ==== src.f ====
snakeVgaPkg.sv
rasterTiming.sv
boardLayer.sv
panelLayer.sv
pixelCompositor.sv
snakeVgaTop.sv
snakeVga_asserts.sv
tbSnakeVga.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tbSnakeVga -f src.f -o simSnakeVga

if ! simOutput=$(./obj_dir/simSnakeVga 2>&1); then
	echo "$simOutput"
	echo "simulation exited with an error"
	exit 1
fi
echo "$simOutput"

if grep -qx "Test completed successfully" <<< "$simOutput"; then
	exit 0
else
	exit 1
fi

// ==== tbSnakeVga.sv ====
module tbSnakeVga;
	timeunit 1ns;
	timeprecision 1ps;

	import snakeVgaPkg::*;

	localparam int posBits = $bits(cellPosT);
	localparam int segBits = bodySegments * posBits;
	// seven frames of tests at most, plus one spare
	localparam int frameCycles   = 800 * 525;
	localparam int timeoutCycles = 8 * frameCycles;

	logic                iVGA_CLK;
	logic                iRST_n;
	stageT               stage;
	cellPosT             head1Pos;
	cellPosT             head2Pos;
	logic [segBits-1:0]  body1;
	logic [segBits-1:0]  body2;
	cellPosT             applePos;
	cellPosT             invincPos;
	timerT               heartsTimer;
	timerT               invincTimer;
	logic                oHS;
	logic                oVS;
	logic                oBLANK_n;
	logic [7:0]          rData;
	logic [7:0]          gData;
	logic [7:0]          bData;

	integer      seed;
	int          errorCount;
	int          checkCount;
	int          cycleCount;
	// cells already taken by the random placement
	int          usedCells [$];
	// requested pixels, expected and captured RGB
	int          reqRow [$];
	int          reqCol [$];
	logic [23:0] reqExp [$];
	logic [23:0] capVal [$];
	logic        capSeen [$];

	snakeVgaTop snakeVgaTop_i (
		.iVGA_CLK    (iVGA_CLK),
		.iRST_n      (iRST_n),
		.stage       (stage),
		.head1Pos    (head1Pos),
		.head2Pos    (head2Pos),
		.body1       (body1),
		.body2       (body2),
		.applePos    (applePos),
		.invincPos   (invincPos),
		.heartsTimer (heartsTimer),
		.invincTimer (invincTimer),
		.oHS         (oHS),
		.oVS         (oVS),
		.oBLANK_n    (oBLANK_n),
		.rData       (rData),
		.gData       (gData),
		.bData       (bData)
	);

	bind snakeVgaTop snakeVgaAsserts snakeVgaAsserts_i (
		.iVGA_CLK (iVGA_CLK),
		.iRST_n   (iRST_n),
		.oHS      (oHS),
		.oVS      (oVS),
		.oBLANK_n (oBLANK_n),
		.rData    (rData),
		.gData    (gData),
		.bData    (bData)
	);

	// 25 MHz pixel clock
	initial begin
		iVGA_CLK = 1'b0;
		forever #20 iVGA_CLK = ~iVGA_CLK;
	end

	// run limit
	always @(posedge iVGA_CLK) begin
		cycleCount++;
		if (cycleCount >= timeoutCycles) begin
			$display("run stopped after %0d cycles without finishing the tests", cycleCount);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// expected values
	//////////////////////////////////////////////////////////////////////

	// 3-3-2 index to 24-bit RGB by bit repetition
	function automatic logic [23:0] expandIndex(colorIndexT idx);
		logic [8:0] redRep;
		logic [8:0] greenRep;
		logic [1:0] blue;
		redRep   = {3{idx[7:5]}};
		greenRep = {3{idx[4:2]}};
		blue     = idx[1:0];
		return {redRep[8:1], greenRep[8:1], {4{blue}}};
	endfunction

	// empty cell colour from row plus column parity
	function automatic colorIndexT checkerIndex(cellPosT pos);
		int cellRow;
		int cellCol;
		cellRow = int'(pos) / 40;
		cellCol = int'(pos) % 40;
		return ((cellRow + cellCol) % 2 == 0) ? colorCheckA : colorCheckB;
	endfunction

	// panel pixel for the given timer levels
	function automatic colorIndexT panelIndexAt(int row, int col, int hearts, int invinc);
		int level;
		if (col <= 520 || col >= 600) begin
			return colorPanel;
		end
		if (row > 60 && row < 80) begin
			level = hearts;
		end else if (row > 100 && row < 120) begin
			level = invinc;
		end else begin
			return colorPanel;
		end
		return (col * 100 < 80 * level + 52000) ? colorBar : colorPanel;
	endfunction

	function automatic int randomBelow(int limit);
		return int'($unsigned($random(seed)) % limit);
	endfunction

	// random cell not handed out before
	function automatic cellPosT pickFreeCell();
		int candidate;
		bit taken;
		do begin
			candidate = randomBelow(1600);
			taken     = 1'b0;
			foreach (usedCells[i]) begin
				if (usedCells[i] == candidate) begin
					taken = 1'b1;
				end
			end
		end while (taken);
		usedCells.push_back(candidate);
		return cellPosT'(candidate);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// stimulus, checking and pixel capture
	//////////////////////////////////////////////////////////////////////

	task automatic checkValue(string testName, logic [31:0] expected, logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			$display("mismatch %s expected %h actual %h", testName, expected, actual);
			errorCount++;
		end
	endtask

	task automatic reportTest(string testName, int errorsBefore);
		$display("%s finished with %0d errors", testName, errorCount - errorsBefore);
	endtask

	task automatic applyBoard(stageT st, cellPosT h1, cellPosT h2, logic [segBits-1:0] b1,
		logic [segBits-1:0] b2, cellPosT ap, cellPosT it);
		@(posedge iVGA_CLK);
		#2;
		stage     = st;
		head1Pos  = h1;
		head2Pos  = h2;
		body1     = b1;
		body2     = b2;
		applePos  = ap;
		invincPos = it;
	endtask

	task automatic applyTimers(timerT hearts, timerT invinc);
		@(posedge iVGA_CLK);
		#2;
		heartsTimer = hearts;
		invincTimer = invinc;
	endtask

	task automatic applyStage(stageT st);
		@(posedge iVGA_CLK);
		#2;
		stage = st;
	endtask

	task automatic addPixel(int row, int col, colorIndexT idx);
		reqRow.push_back(row);
		reqCol.push_back(col);
		reqExp.push_back(expandIndex(idx));
	endtask

	// random pixel inside a board cell
	task automatic addCellPixel(cellPosT pos, colorIndexT idx);
		int row;
		int col;
		row = (int'(pos) / 40) * 12 + randomBelow(12);
		col = (int'(pos) % 40) * 12 + randomBelow(12);
		addPixel(row, col, idx);
	endtask

	// one frame from the end of vsync
	// lines and columns follow oBLANK_n
	task automatic captureFrame(output int blankErrors);
		int   line;
		int   col;
		int   remaining;
		logic wasActive;
		blankErrors = 0;
		remaining   = reqRow.size();
		foreach (reqRow[i]) begin
			capVal.push_back(24'h0);
			capSeen.push_back(1'b0);
		end
		@(negedge iVGA_CLK);
		while (oVS !== 1'b0) @(negedge iVGA_CLK);
		while (oVS !== 1'b1) @(negedge iVGA_CLK);
		line      = -1;
		col       = 0;
		wasActive = 1'b0;
		while (remaining > 0 && line < 480) begin
			@(negedge iVGA_CLK);
			if (oBLANK_n === 1'b1) begin
				// new line on each rising oBLANK_n
				if (!wasActive) begin
					line++;
					col = 0;
				end
				foreach (reqRow[i]) begin
					if (!capSeen[i] && reqRow[i] == line && reqCol[i] == col) begin
						capVal[i]  = {rData, gData, bData};
						capSeen[i] = 1'b1;
						remaining--;
					end
				end
				col++;
			end else if ({rData, gData, bData} !== 24'h0) begin
				blankErrors++;
			end
			wasActive = oBLANK_n;
		end
	endtask

	task automatic scanPixels(string testName);
		int blankErrors;
		captureFrame(blankErrors);
		foreach (reqRow[i]) begin
			if (!capSeen[i]) begin
				$display("%s pixel at row %0d column %0d was never shown", testName,
					reqRow[i], reqCol[i]);
				errorCount++;
			end else begin
				checkValue($sformatf("%s row %0d col %0d", testName, reqRow[i], reqCol[i]),
					32'(reqExp[i]), 32'(capVal[i]));
			end
		end
		// nonzero RGB seen while blanked
		checkValue({testName, " blanking"}, 32'd0, 32'(blankErrors));
		reqRow.delete();
		reqCol.delete();
		reqExp.delete();
		capVal.delete();
		capSeen.delete();
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	task automatic syncTiming();
		int   errorsAtStart;
		int   lowCount;
		int   highCount;
		int   vsLow;
		int   lineCount;
		logic prevHs;
		errorsAtStart = errorCount;
		// line measured from one oHS fall to the next
		@(negedge iVGA_CLK);
		while (oHS !== 1'b1) @(negedge iVGA_CLK);
		while (oHS !== 1'b0) @(negedge iVGA_CLK);
		lowCount = 0;
		while (oHS === 1'b0) begin
			lowCount++;
			@(negedge iVGA_CLK);
		end
		highCount = 0;
		while (oHS === 1'b1) begin
			highCount++;
			@(negedge iVGA_CLK);
		end
		checkValue("syncTiming hsync width", 32'd96, 32'(lowCount));
		checkValue("syncTiming clocks per line", 32'd800, 32'(lowCount + highCount));
		// frame from one oVS fall to the next
		// lines counted as oHS falls
		while (oVS !== 1'b1) @(negedge iVGA_CLK);
		while (oVS !== 1'b0) @(negedge iVGA_CLK);
		vsLow     = 0;
		lineCount = 0;
		prevHs    = oHS;
		while (oVS === 1'b0) begin
			vsLow++;
			@(negedge iVGA_CLK);
			if (prevHs === 1'b1 && oHS === 1'b0) begin
				lineCount++;
			end
			prevHs = oHS;
		end
		while (oVS === 1'b1) begin
			@(negedge iVGA_CLK);
			if (prevHs === 1'b1 && oHS === 1'b0) begin
				lineCount++;
			end
			prevHs = oHS;
		end
		checkValue("syncTiming vsync width lines", 32'd2, 32'(vsLow / 800));
		checkValue("syncTiming vsync partial line", 32'd0, 32'(vsLow % 800));
		checkValue("syncTiming lines per frame", 32'd525, 32'(lineCount));
		reportTest("syncTiming", errorsAtStart);
	endtask

	task automatic boardCells();
		int                 errorsAtStart;
		cellPosT            h1;
		cellPosT            h2;
		cellPosT            ap;
		cellPosT            it;
		cellPosT            empty;
		logic [segBits-1:0] b1;
		logic [segBits-1:0] b2;
		errorsAtStart = errorCount;
		usedCells.delete();
		h1 = pickFreeCell();
		h2 = pickFreeCell();
		for (int k = 0; k < bodySegments; k++) begin
			b1[k*posBits +: posBits] = pickFreeCell();
			b2[k*posBits +: posBits] = pickFreeCell();
		end
		ap    = pickFreeCell();
		it    = pickFreeCell();
		empty = pickFreeCell();
		applyBoard(stagePlaying, h1, h2, b1, b2, ap, it);
		addCellPixel(h1, colorHead);
		addCellPixel(h2, colorHead);
		for (int k = 0; k < bodySegments; k++) begin
			addCellPixel(cellPosT'(b1[k*posBits +: posBits]), colorBody);
			addCellPixel(cellPosT'(b2[k*posBits +: posBits]), colorBody);
		end
		addCellPixel(ap, colorApple);
		addCellPixel(it, colorInvinc);
		addCellPixel(empty, checkerIndex(empty));
		scanPixels("boardCells");
		reportTest("boardCells", errorsAtStart);
	endtask

	task automatic cellPriority();
		int                 errorsAtStart;
		cellPosT            h1;
		cellPosT            h2;
		logic [segBits-1:0] b1;
		logic [segBits-1:0] b2;
		errorsAtStart = errorCount;
		usedCells.delete();
		h1 = pickFreeCell();
		h2 = pickFreeCell();
		for (int k = 0; k < bodySegments; k++) begin
			b1[k*posBits +: posBits] = pickFreeCell();
			b2[k*posBits +: posBits] = pickFreeCell();
		end
		// apple over body segment 4, item over the second head
		applyBoard(stagePlaying, h1, h2, b1, b2, cellPosT'(b1[4*posBits +: posBits]), h2);
		addCellPixel(cellPosT'(b1[4*posBits +: posBits]), colorApple);
		addCellPixel(h2, colorInvinc);
		addCellPixel(h1, colorHead);
		addCellPixel(cellPosT'(b2[4*posBits +: posBits]), colorBody);
		scanPixels("cellPriority");
		reportTest("cellPriority", errorsAtStart);
	endtask

	task automatic timerBars();
		int errorsAtStart;
		int barRows [6];
		int edgeCols [6];
		int outRows [5];
		errorsAtStart = errorCount;
		barRows       = '{61, 70, 79, 101, 110, 119};
		edgeCols      = '{520, 521, 559, 560, 599, 600};
		outRows       = '{60, 80, 100, 120, 300};
		applyTimers(32'd50, 32'd100);
		// both sides of each bar edge
		foreach (barRows[r]) begin
			foreach (edgeCols[c]) begin
				addPixel(barRows[r], edgeCols[c],
					panelIndexAt(barRows[r], edgeCols[c], 50, 100));
			end
		end
		// rows around the bars stay panel colour
		foreach (outRows[r]) begin
			addPixel(outRows[r], 540, colorPanel);
		end
		scanPixels("timerBars");
		reportTest("timerBars", errorsAtStart);
	endtask

	task automatic otherStages();
		int errorsAtStart;
		errorsAtStart = errorCount;
		applyStage(stageTitle);
		addPixel(0, 0, colorBlack);
		addPixel(30, 200, colorBlack);
		addPixel(70, 540, colorBlack);
		addPixel(110, 590, colorBlack);
		addPixel(150, 479, colorBlack);
		scanPixels("otherStages title");
		applyStage(stageHighscore);
		addPixel(5, 639, colorBlack);
		addPixel(65, 530, colorBlack);
		addPixel(140, 12, colorBlack);
		addPixel(160, 480, colorBlack);
		scanPixels("otherStages highscore");
		reportTest("otherStages", errorsAtStart);
	endtask

	initial begin
		seed        = 32'hb014;
		errorCount  = 0;
		checkCount  = 0;
		cycleCount  = 0;
		iRST_n      = 1'b0;
		stage       = stageTitle;
		head1Pos    = '0;
		head2Pos    = '0;
		body1       = '0;
		body2       = '0;
		applePos    = '0;
		invincPos   = '0;
		heartsTimer = '0;
		invincTimer = '0;
		repeat (5) @(posedge iVGA_CLK);
		#2;
		iRST_n = 1'b1;
		syncTiming();
		boardCells();
		cellPriority();
		timerBars();
		otherStages();
		$display("%0d checks run, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== snakeVga_asserts.sv ====
module snakeVgaAsserts (
	input logic       iVGA_CLK,
	input logic       iRST_n,
	input logic       oHS,
	input logic       oVS,
	input logic       oBLANK_n,
	input logic [7:0] rData,
	input logic [7:0] gData,
	input logic [7:0] bData
);
	timeunit 1ns;
	timeprecision 1ps;

	// low cycles of oHS seen before the current one
	logic [7:0] hsLowRun;

	always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
		if (!iRST_n) begin
			hsLowRun <= '0;
		end else if (oHS) begin
			hsLowRun <= '0;
		end else if (hsLowRun != 8'hFF) begin
			hsLowRun <= hsLowRun + 8'd1;
		end
	end

	// no picture inside a sync pulse
	blankDuringSync: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		(!oHS || !oVS) |-> !oBLANK_n)
		else $error("oBLANK_n high during a sync pulse");

	// RGB black whenever blanked
	rgbZeroInBlank: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		!oBLANK_n |-> (rData == 8'h00 && gData == 8'h00 && bData == 8'h00))
		else $error("RGB not zero during blanking");

	// hsync pulse is 96 clocks at most
	hsPulseWidth: assert property (@(posedge iVGA_CLK) disable iff (!iRST_n)
		!oHS |-> (hsLowRun < 8'd96))
		else $error("oHS low for more than 96 cycles");

endmodule

// ==== snakeVgaTop.sv ====
module snakeVgaTop (
	input  logic                    iVGA_CLK,
	input  logic                    iRST_n,
	input  snakeVgaPkg::stageT      stage,
	input  snakeVgaPkg::cellPosT    head1Pos,
	input  snakeVgaPkg::cellPosT    head2Pos,
	input  logic [snakeVgaPkg::bodySegments*$bits(snakeVgaPkg::cellPosT)-1:0] body1,
	input  logic [snakeVgaPkg::bodySegments*$bits(snakeVgaPkg::cellPosT)-1:0] body2,
	input  snakeVgaPkg::cellPosT    applePos,
	input  snakeVgaPkg::cellPosT    invincPos,
	input  snakeVgaPkg::timerT      heartsTimer,
	input  snakeVgaPkg::timerT      invincTimer,
	output logic                    oHS,
	output logic                    oVS,
	output logic                    oBLANK_n,
	output logic [7:0]              rData,
	output logic [7:0]              gData,
	output logic [7:0]              bData
);
	import snakeVgaPkg::*;

	// raster position and levels
	pixelCoordT pixelRow;
	pixelCoordT pixelCol;
	logic       activeVideo;
	logic       hSyncRaw;
	logic       vSyncRaw;

	// layer colours, one cycle behind the raster
	colorIndexT boardColor;
	colorIndexT panelColor;

	//////////////////////////////////////////////////////////////////////
	// raster, two layers side by side, then the compositor
	//////////////////////////////////////////////////////////////////////

	rasterTiming rasterTiming_i (
		.iVGA_CLK    (iVGA_CLK),
		.iRST_n      (iRST_n),
		.pixelRow    (pixelRow),
		.pixelCol    (pixelCol),
		.activeVideo (activeVideo),
		.hSyncRaw    (hSyncRaw),
		.vSyncRaw    (vSyncRaw)
	);

	boardLayer boardLayer_i (
		.iVGA_CLK   (iVGA_CLK),
		.iRST_n     (iRST_n),
		.pixelRow   (pixelRow),
		.pixelCol   (pixelCol),
		.head1Pos   (head1Pos),
		.head2Pos   (head2Pos),
		.body1      (body1),
		.body2      (body2),
		.applePos   (applePos),
		.invincPos  (invincPos),
		.boardColor (boardColor)
	);

	panelLayer panelLayer_i (
		.iVGA_CLK    (iVGA_CLK),
		.iRST_n      (iRST_n),
		.pixelRow    (pixelRow),
		.pixelCol    (pixelCol),
		.heartsTimer (heartsTimer),
		.invincTimer (invincTimer),
		.panelColor  (panelColor)
	);

	pixelCompositor pixelCompositor_i (
		.iVGA_CLK    (iVGA_CLK),
		.iRST_n      (iRST_n),
		.stage       (stage),
		.boardColor  (boardColor),
		.panelColor  (panelColor),
		.pixelCol    (pixelCol),
		.activeVideo (activeVideo),
		.hSyncRaw    (hSyncRaw),
		.vSyncRaw    (vSyncRaw),
		.oHS         (oHS),
		.oVS         (oVS),
		.oBLANK_n    (oBLANK_n),
		.rData       (rData),
		.gData       (gData),
		.bData       (bData)
	);

endmodule

// ==== pixelCompositor.sv ====
module pixelCompositor (
	input  logic                    iVGA_CLK,
	input  logic                    iRST_n,
	input  snakeVgaPkg::stageT      stage,
	input  snakeVgaPkg::colorIndexT boardColor,
	input  snakeVgaPkg::colorIndexT panelColor,
	input  snakeVgaPkg::pixelCoordT pixelCol,
	input  logic                    activeVideo,
	input  logic                    hSyncRaw,
	input  logic                    vSyncRaw,
	output logic                    oHS,
	output logic                    oVS,
	output logic                    oBLANK_n,
	output logic [7:0]              rData,
	output logic [7:0]              gData,
	output logic [7:0]              bData
);
	import snakeVgaPkg::*;

	// raster side waits for the layer registers
	localparam int alignDepth = renderLatency - 1;

	pixelCoordT colDly    [alignDepth];
	logic       activeDly [alignDepth];
	logic       hsDly     [alignDepth];
	logic       vsDly     [alignDepth];
	colorIndexT pixelIndex;

	//////////////////////////////////////////////////////////////////////
	// raster alignment
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
		if (!iRST_n) begin
			for (int k = 0; k < alignDepth; k++) begin
				colDly[k]    <= '0;
				activeDly[k] <= 1'b0;
				hsDly[k]     <= 1'b1;
				vsDly[k]     <= 1'b1;
			end
		end else begin
			colDly[0]    <= pixelCol;
			activeDly[0] <= activeVideo;
			hsDly[0]     <= hSyncRaw;
			vsDly[0]     <= vSyncRaw;
			for (int k = 1; k < alignDepth; k++) begin
				colDly[k]    <= colDly[k-1];
				activeDly[k] <= activeDly[k-1];
				hsDly[k]     <= hsDly[k-1];
				vsDly[k]     <= vsDly[k-1];
			end
		end
	end

	// board on the left, panel on the right, black outside play
	always_comb begin
		if (stage != stagePlaying) begin
			pixelIndex = colorBlack;
		end else if (colDly[alignDepth-1] < pixelCoordT'(boardPixels)) begin
			pixelIndex = boardColor;
		end else begin
			pixelIndex = panelColor;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// 3-3-2 expansion and output registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
		if (!iRST_n) begin
			oHS      <= 1'b1;
			oVS      <= 1'b1;
			oBLANK_n <= 1'b0;
			rData    <= '0;
			gData    <= '0;
			bData    <= '0;
		end else begin
			oHS      <= hsDly[alignDepth-1];
			oVS      <= vsDly[alignDepth-1];
			oBLANK_n <= activeDly[alignDepth-1];
			// black during blanking
			if (activeDly[alignDepth-1]) begin
				rData <= {pixelIndex[7:5], pixelIndex[7:5], pixelIndex[7:6]};
				gData <= {pixelIndex[4:2], pixelIndex[4:2], pixelIndex[4:3]};
				bData <= {4{pixelIndex[1:0]}};
			end else begin
				rData <= '0;
				gData <= '0;
				bData <= '0;
			end
		end
	end

endmodule

// ==== panelLayer.sv ====
module panelLayer (
	input  logic                    iVGA_CLK,
	input  logic                    iRST_n,
	input  snakeVgaPkg::pixelCoordT pixelRow,
	input  snakeVgaPkg::pixelCoordT pixelCol,
	input  snakeVgaPkg::timerT      heartsTimer,
	input  snakeVgaPkg::timerT      invincTimer,
	output snakeVgaPkg::colorIndexT panelColor
);
	import snakeVgaPkg::*;

	logic       inBarCols;
	logic       inHeartsRows;
	logic       inInvincRows;
	colorIndexT colorNext;

	// bar edge at barLeft + barWidth * level / 100, kept in integers
	function automatic logic barLit(pixelCoordT col, timerT level);
		logic [31:0] colScaled;
		logic [31:0] edgeScaled;
		colScaled  = 32'(col) * 32'd100;
		edgeScaled = 32'(barWidth) * level + 32'(barLeft * 100);
		return colScaled < edgeScaled;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// bar windows, all bounds exclusive
	//////////////////////////////////////////////////////////////////////

	assign inBarCols = (pixelCol > pixelCoordT'(barLeft)) &&
		(pixelCol < pixelCoordT'(barRight));
	assign inHeartsRows = (pixelRow > pixelCoordT'(heartsRowTop)) &&
		(pixelRow < pixelCoordT'(heartsRowBottom));
	assign inInvincRows = (pixelRow > pixelCoordT'(invincRowTop)) &&
		(pixelRow < pixelCoordT'(invincRowBottom));

	always_comb begin
		colorNext = colorPanel;
		// hearts bar
		if (inBarCols && inHeartsRows && barLit(pixelCol, heartsTimer)) begin
			colorNext = colorBar;
		end
		// invincibility bar
		if (inBarCols && inInvincRows && barLit(pixelCol, invincTimer)) begin
			colorNext = colorBar;
		end
	end

	// same stage as the board layer
	always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
		if (!iRST_n) begin
			panelColor <= colorBlack;
		end else begin
			panelColor <= colorNext;
		end
	end

endmodule

// ==== boardLayer.sv ====
module boardLayer (
	input  logic                    iVGA_CLK,
	input  logic                    iRST_n,
	input  snakeVgaPkg::pixelCoordT pixelRow,
	input  snakeVgaPkg::pixelCoordT pixelCol,
	input  snakeVgaPkg::cellPosT    head1Pos,
	input  snakeVgaPkg::cellPosT    head2Pos,
	input  logic [snakeVgaPkg::bodySegments*$bits(snakeVgaPkg::cellPosT)-1:0] body1,
	input  logic [snakeVgaPkg::bodySegments*$bits(snakeVgaPkg::cellPosT)-1:0] body2,
	input  snakeVgaPkg::cellPosT    applePos,
	input  snakeVgaPkg::cellPosT    invincPos,
	output snakeVgaPkg::colorIndexT boardColor
);
	import snakeVgaPkg::*;

	localparam int posBits  = $bits(cellPosT);
	localparam int segTotal = 2 * bodySegments;

	pixelCoordT                   cellRow;
	pixelCoordT                   cellCol;
	cellPosT                      cellNum;
	logic                         inBoard;
	logic [segTotal*posBits-1:0]  bodyAll;
	logic [segTotal-1:0]          segHit;
	logic                         bodyHit;
	logic                         headHit;
	logic                         appleHit;
	logic                         invincHit;
	colorIndexT                   colorNext;

	//////////////////////////////////////////////////////////////////////
	// pixel to cell
	//////////////////////////////////////////////////////////////////////

	// constant divide, 12 pixels per cell
	assign cellRow = pixelCoordT'(pixelRow / cellPixels);
	assign cellCol = pixelCoordT'(pixelCol / cellPixels);
	assign cellNum = cellPosT'(cellRow * boardCells + cellCol);

	// outside the 480 x 480 square nothing matches
	assign inBoard = (pixelCol < pixelCoordT'(boardPixels)) &&
		(pixelRow < pixelCoordT'(boardPixels));

	//////////////////////////////////////////////////////////////////////
	// segment matching
	//////////////////////////////////////////////////////////////////////

	// snake 2 on top, segment 0 of snake 1 in the low bits
	assign bodyAll = {body2, body1};

	// one comparator per body segment
	genvar i;
	generate
		for (i = 0; i < segTotal; i++) begin : gSegMatch
			assign segHit[i] = (bodyAll[i*posBits +: posBits] == cellNum);
		end
	endgenerate

	assign bodyHit   = inBoard && (|segHit);
	assign headHit   = inBoard && ((head1Pos == cellNum) || (head2Pos == cellNum));
	assign appleHit  = inBoard && (applePos == cellNum);
	assign invincHit = inBoard && (invincPos == cellNum);

	//////////////////////////////////////////////////////////////////////
	// colour choice, later tests win
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// checkerboard from cell parity
		if (cellRow[0] ^ cellCol[0]) begin
			colorNext = colorCheckB;
		end else begin
			colorNext = colorCheckA;
		end
		if (bodyHit) begin
			colorNext = colorBody;
		end
		if (headHit) begin
			colorNext = colorHead;
		end
		if (appleHit) begin
			colorNext = colorApple;
		end
		// item beats everything
		if (invincHit) begin
			colorNext = colorInvinc;
		end
	end

	// one cycle after the raster position
	always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
		if (!iRST_n) begin
			boardColor <= colorBlack;
		end else begin
			boardColor <= colorNext;
		end
	end

endmodule

// ==== rasterTiming.sv ====
module rasterTiming (
	input  logic                   iVGA_CLK,
	input  logic                   iRST_n,
	output snakeVgaPkg::pixelCoordT pixelRow,
	output snakeVgaPkg::pixelCoordT pixelCol,
	output logic                   activeVideo,
	output logic                   hSyncRaw,
	output logic                   vSyncRaw
);
	import snakeVgaPkg::*;

	pixelCoordT colNext;
	pixelCoordT rowNext;
	logic       lineEnd;
	logic       frameEnd;
	logic       hPulse;
	logic       vPulse;
	logic       inPicture;

	//////////////////////////////////////////////////////////////////////
	// next raster position
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		lineEnd  = (pixelCol == pixelCoordT'(hTotal - 1));
		frameEnd = (pixelRow == pixelCoordT'(vTotal - 1));

		// column wraps every line
		if (lineEnd) begin
			colNext = '0;
		end else begin
			colNext = pixelCol + 1'b1;
		end

		// line only moves at the end of a line
		if (lineEnd && frameEnd) begin
			rowNext = '0;
		end else if (lineEnd) begin
			rowNext = pixelRow + 1'b1;
		end else begin
			rowNext = pixelRow;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// decode from the next position
	//////////////////////////////////////////////////////////////////////

	// decoded one step early so the levels line up with the counters
	always_comb begin
		hPulse    = (colNext >= pixelCoordT'(hActive + hFront)) &&
			(colNext < pixelCoordT'(hActive + hFront + hSync));
		vPulse    = (rowNext >= pixelCoordT'(vActive + vFront)) &&
			(rowNext < pixelCoordT'(vActive + vFront + vSync));
		inPicture = (colNext < pixelCoordT'(hActive)) && (rowNext < pixelCoordT'(vActive));
	end

	// counters plus registered levels
	always_ff @(posedge iVGA_CLK or negedge iRST_n) begin
		if (!iRST_n) begin
			pixelCol    <= '0;
			pixelRow    <= '0;
			// levels match position 0,0
			activeVideo <= 1'b1;
			hSyncRaw    <= 1'b1;
			vSyncRaw    <= 1'b1;
		end else begin
			pixelCol    <= colNext;
			pixelRow    <= rowNext;
			activeVideo <= inPicture;
			// syncs are active low
			hSyncRaw    <= ~hPulse;
			vSyncRaw    <= ~vPulse;
		end
	end

endmodule

// ==== snakeVgaPkg.sv ====
package snakeVgaPkg;

	//////////////////////////////////////////////////////////////////////
	// shared types
	//////////////////////////////////////////////////////////////////////

	// screen row or column, covers the full 800 x 525 raster
	typedef logic [9:0] pixelCoordT;

	// board cell number, row * 40 + column
	typedef logic [10:0] cellPosT;

	// 3-3-2 colour index, red in the top bits
	typedef logic [7:0] colorIndexT;

	// timer level from the game logic, 0 to 100
	typedef logic [31:0] timerT;

	// game stage as driven by the game logic
	typedef enum logic [31:0] {
		stageTitle     = 32'd0,
		stagePlaying   = 32'd2,
		stageHighscore = 32'd3
	} stageT;

	//////////////////////////////////////////////////////////////////////
	// 640 x 480 at 60 Hz, 25 MHz pixel clock
	//////////////////////////////////////////////////////////////////////

	localparam int hActive = 640;
	localparam int hFront  = 16;
	localparam int hSync   = 96;
	localparam int hBack   = 48;
	localparam int hTotal  = hActive + hFront + hSync + hBack;

	localparam int vActive = 480;
	localparam int vFront  = 10;
	localparam int vSync   = 2;
	localparam int vBack   = 33;
	localparam int vTotal  = vActive + vFront + vSync + vBack;

	// board geometry, 40 x 40 cells of 12 pixels
	localparam int cellPixels   = 12;
	localparam int boardCells   = 40;
	localparam int boardPixels  = cellPixels * boardCells;
	localparam int bodySegments = 10;

	// side panel bars
	localparam int barLeft         = 520;
	localparam int barRight        = 600;
	localparam int barWidth        = barRight - barLeft;
	localparam int heartsRowTop    = 60;
	localparam int heartsRowBottom = 80;
	localparam int invincRowTop    = 100;
	localparam int invincRowBottom = 120;

	// colour indices
	localparam colorIndexT colorBody   = 8'h14;
	localparam colorIndexT colorHead   = 8'h1F;
	localparam colorIndexT colorApple  = 8'hE0;
	localparam colorIndexT colorInvinc = 8'h03;
	localparam colorIndexT colorCheckA = 8'h49;
	localparam colorIndexT colorCheckB = 8'h6D;
	localparam colorIndexT colorPanel  = 8'h1C;
	localparam colorIndexT colorBar    = 8'h55;
	localparam colorIndexT colorBlack  = 8'h00;

	// raster position to RGB, one layer stage plus one output stage
	localparam int renderLatency = 2;

endpackage
